//--- include/backend_consts.svh
`ifndef BACKEND_CONSTS_SVH
`define BACKEND_CONSTS_SVH

// reorder buffer geometry
`define ROB_DEPTH 8
// 3 index bits plus a wrap flag
`define ROB_IDX_W 4

`define FTQ_IDX_W 4

// address and operand width
`define XLEN 32

// branch lanes
`define BRU_NUM 2
`define BRU0_LAT 1
`define BRU1_LAT 3

`endif

//--- rtl/backend_pkg.sv
`include "backend_consts.svh"

package backend_pkg;

    // branch writeback payload
    typedef struct packed {
        logic [`ROB_IDX_W-1:0] rob_idx;
        logic [`FTQ_IDX_W-1:0] ftq_idx;
        logic                  mispred;
        logic [`XLEN-1:0]      target;
    } branchwb_t;

    // true when rob index a is older than rob index b
    // msb is the wrap flag, the rest is the slot
    function automatic logic is_older(
        input logic [`ROB_IDX_W-1:0] a,
        input logic [`ROB_IDX_W-1:0] b
    );
        logic a_flag;
        logic b_flag;
        logic [`ROB_IDX_W-2:0] a_slot;
        logic [`ROB_IDX_W-2:0] b_slot;

        a_flag = a[`ROB_IDX_W-1];
        b_flag = b[`ROB_IDX_W-1];
        a_slot = a[`ROB_IDX_W-2:0];
        b_slot = b[`ROB_IDX_W-2:0];

        if (a_flag == b_flag) begin
            return a_slot < b_slot;
        end
        // tail has wrapped past one of them
        return a_slot > b_slot;
    endfunction

endpackage

//--- rtl/disp_if.sv
`timescale 1ns/1ps
`include "backend_consts.svh"

interface disp_if;

    logic                  vld;
    logic [`ROB_IDX_W-1:0] rob_idx;
    logic [`FTQ_IDX_W-1:0] ftq_idx;
    logic [`XLEN-1:0]      src_a;
    logic [`XLEN-1:0]      src_b;
    logic [`XLEN-1:0]      offset;

    // no ready, the lane takes every valid beat
    modport src  (output vld, rob_idx, ftq_idx, src_a, src_b, offset);
    modport sink (input  vld, rob_idx, ftq_idx, src_a, src_b, offset);

endinterface

//--- rtl/bru_wb_if.sv
`timescale 1ns/1ps
`include "backend_consts.svh"

interface bru_wb_if;

    logic                  vld;
    logic [`ROB_IDX_W-1:0] rob_idx;
    logic [`FTQ_IDX_W-1:0] ftq_idx;
    logic                  mispred;
    logic [`XLEN-1:0]      target;

    // lane drives, control block and selector listen
    modport src  (output vld, rob_idx, ftq_idx, mispred, target);
    modport sink (input  vld, rob_idx, ftq_idx, mispred, target);

endinterface

//--- rtl/bru.sv
`timescale 1ns/1ps
`include "backend_consts.svh"

module bru #(
    parameter int LAT = 1
) (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_squash_vld,
    disp_if.sink                  disp,
    output logic [`FTQ_IDX_W-1:0] o_read_ftq_idx,
    input  logic [`XLEN-1:0]      i_start_addr,
    input  logic [`XLEN-1:0]      i_next_addr,
    bru_wb_if.src                 wb
);

    logic                  taken;
    backend_pkg::branchwb_t res;
    logic [LAT-1:0]        stage_vld;
    backend_pkg::branchwb_t stage_data [LAT];

    assign o_read_ftq_idx = disp.ftq_idx;

    // resolve in the first stage
    always_comb begin
        taken       = (disp.src_a == disp.src_b);
        res.rob_idx = disp.rob_idx;
        res.ftq_idx = disp.ftq_idx;
        res.target  = taken ? (i_start_addr + disp.offset) : (i_start_addr + `XLEN'(4));
        res.mispred = (res.target != i_next_addr);
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n || i_squash_vld) begin
            stage_vld <= '0;
        end else begin
            stage_vld[0] <= disp.vld;
            for (int i = 1; i < LAT; i++) begin
                stage_vld[i] <= stage_vld[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        stage_data[0] <= res;
        for (int i = 1; i < LAT; i++) begin
            stage_data[i] <= stage_data[i-1];
        end
    end

    assign wb.vld     = stage_vld[LAT-1];
    assign wb.rob_idx = stage_data[LAT-1].rob_idx;
    assign wb.ftq_idx = stage_data[LAT-1].ftq_idx;
    assign wb.mispred = stage_data[LAT-1].mispred;
    assign wb.target  = stage_data[LAT-1].target;

endmodule

//--- rtl/exe_block.sv
`timescale 1ns/1ps
`include "backend_consts.svh"

module exe_block (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_squash_vld,

    disp_if.sink                  disp0,
    disp_if.sink                  disp1,
    bru_wb_if.src                 wb0,
    bru_wb_if.src                 wb1,

    // combinational ftq read, one port per lane
    output logic [`FTQ_IDX_W-1:0] o_read_ftq_idx        [`BRU_NUM],
    input  logic [`XLEN-1:0]      i_read_ftq_start_addr [`BRU_NUM],
    input  logic [`XLEN-1:0]      i_read_ftq_next_addr  [`BRU_NUM]
);

    // lane 0 takes even rob entries
    bru #(
        .LAT ( `BRU0_LAT )
    ) u_bru0 (
        .clk            ( clk                      ),
        .i_rst_n        ( i_rst_n                  ),
        .i_squash_vld   ( i_squash_vld             ),
        .disp           ( disp0                    ),
        .o_read_ftq_idx ( o_read_ftq_idx[0]        ),
        .i_start_addr   ( i_read_ftq_start_addr[0] ),
        .i_next_addr    ( i_read_ftq_next_addr[0]  ),
        .wb             ( wb0                      )
    );

    // lane 1 takes odd entries, slower
    bru #(
        .LAT ( `BRU1_LAT )
    ) u_bru1 (
        .clk            ( clk                      ),
        .i_rst_n        ( i_rst_n                  ),
        .i_squash_vld   ( i_squash_vld             ),
        .disp           ( disp1                    ),
        .o_read_ftq_idx ( o_read_ftq_idx[1]        ),
        .i_start_addr   ( i_read_ftq_start_addr[1] ),
        .i_next_addr    ( i_read_ftq_next_addr[1]  ),
        .wb             ( wb1                      )
    );

endmodule

//--- rtl/oldest_select.sv
`timescale 1ns/1ps
`include "backend_consts.svh"

module oldest_select #(
    parameter type dtype = logic
) (
    input  logic                  i_vld     [2],
    input  logic [`ROB_IDX_W-1:0] i_rob_idx [2],
    input  dtype                  i_datas   [2],
    output logic                  o_vld,
    output dtype                  o_oldest_data
);

    logic pick1;

    // lane 1 wins when alone or older
    assign pick1 = i_vld[1] && (!i_vld[0] || backend_pkg::is_older(i_rob_idx[1], i_rob_idx[0]));

    assign o_vld         = i_vld[0] || i_vld[1];
    assign o_oldest_data = pick1 ? i_datas[1] : i_datas[0];

    // the lanes never hold the same rob entry
    always_comb begin
        if (i_vld[0] && i_vld[1]) begin
            a_distinct_rob: assert final (i_rob_idx[0] != i_rob_idx[1])
                else $error("both lanes write back rob entry %0d", i_rob_idx[0]);
        end
    end

endmodule

//--- rtl/ctrl_block.sv
`timescale 1ns/1ps
`include "backend_consts.svh"

module ctrl_block (
    input  logic                   clk,
    input  logic                   i_rst_n,

    input  logic                   i_inst_vld,
    output logic                   o_inst_rdy,
    input  logic [`FTQ_IDX_W-1:0]  i_inst_ftq_idx,
    input  logic [`XLEN-1:0]       i_inst_src_a,
    input  logic [`XLEN-1:0]       i_inst_src_b,
    input  logic [`XLEN-1:0]       i_inst_offset,

    disp_if.src                    disp0,
    disp_if.src                    disp1,
    bru_wb_if.sink                 wb0,
    bru_wb_if.sink                 wb1,

    input  logic                   i_mispred_vld,
    input  backend_pkg::branchwb_t i_mispred_info,

    output logic                   o_commit_vld,
    output logic [`FTQ_IDX_W-1:0]  o_commit_ftq_idx,
    output logic                   o_squash_vld,
    output logic [`FTQ_IDX_W-1:0]  o_squash_ftq_idx,
    output logic [`XLEN-1:0]       o_squash_target
);

    localparam int SLOT_W = `ROB_IDX_W - 1;

    logic [`ROB_IDX_W-1:0] head, tail, disp_ptr;
    logic [`ROB_IDX_W-1:0] occ, wb0_ofs, wb1_ofs;
    logic [`ROB_DEPTH-1:0] done_q;
    logic [`FTQ_IDX_W-1:0] ftq_q    [`ROB_DEPTH];
    logic [`XLEN-1:0]      src_a_q  [`ROB_DEPTH];
    logic [`XLEN-1:0]      src_b_q  [`ROB_DEPTH];
    logic [`XLEN-1:0]      offset_q [`ROB_DEPTH];

    logic                   mp_vld;
    backend_pkg::branchwb_t mp_info;
    logic full, alloc, disp_go, commit, squash;

    assign occ   = tail - head;
    assign full  = (occ == `ROB_DEPTH);
    assign alloc = i_inst_vld && o_inst_rdy;

    // oldest entry done, and maybe the recorded mispredict
    assign commit = (head != tail) && done_q[head[SLOT_W-1:0]];
    assign squash = commit && mp_vld && (mp_info.rob_idx == head);

    assign o_inst_rdy = !full && !squash;
    assign disp_go    = (disp_ptr != tail) && !squash;

    // even entries to lane 0, odd to lane 1
    assign disp0.vld     = disp_go && !disp_ptr[0];
    assign disp1.vld     = disp_go && disp_ptr[0];
    assign disp0.rob_idx = disp_ptr;
    assign disp1.rob_idx = disp_ptr;
    assign disp0.ftq_idx = ftq_q[disp_ptr[SLOT_W-1:0]];
    assign disp1.ftq_idx = ftq_q[disp_ptr[SLOT_W-1:0]];
    assign disp0.src_a   = src_a_q[disp_ptr[SLOT_W-1:0]];
    assign disp1.src_a   = src_a_q[disp_ptr[SLOT_W-1:0]];
    assign disp0.src_b   = src_b_q[disp_ptr[SLOT_W-1:0]];
    assign disp1.src_b   = src_b_q[disp_ptr[SLOT_W-1:0]];
    assign disp0.offset  = offset_q[disp_ptr[SLOT_W-1:0]];
    assign disp1.offset  = offset_q[disp_ptr[SLOT_W-1:0]];

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            head     <= '0;
            tail     <= '0;
            disp_ptr <= '0;
            done_q   <= '0;
            mp_vld   <= 1'b0;
        end else begin
            if (commit) begin
                head <= head + 1'b1;
            end
            if (squash) begin
                // flush everything younger than the committing entry
                tail     <= head + 1'b1;
                disp_ptr <= head + 1'b1;
                mp_vld   <= 1'b0;
            end else begin
                if (alloc) begin
                    tail <= tail + 1'b1;
                    done_q[tail[SLOT_W-1:0]] <= 1'b0;
                end
                if (disp_go) begin
                    disp_ptr <= disp_ptr + 1'b1;
                end
                if (wb0.vld) begin
                    done_q[wb0.rob_idx[SLOT_W-1:0]] <= 1'b1;
                end
                if (wb1.vld) begin
                    done_q[wb1.rob_idx[SLOT_W-1:0]] <= 1'b1;
                end
                // keep only the oldest mispredict
                if (i_mispred_vld &&
                    (!mp_vld || backend_pkg::is_older(i_mispred_info.rob_idx, mp_info.rob_idx))) begin
                    mp_vld <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            ftq_q[tail[SLOT_W-1:0]]    <= i_inst_ftq_idx;
            src_a_q[tail[SLOT_W-1:0]]  <= i_inst_src_a;
            src_b_q[tail[SLOT_W-1:0]]  <= i_inst_src_b;
            offset_q[tail[SLOT_W-1:0]] <= i_inst_offset;
        end
        if (!squash && i_mispred_vld &&
            (!mp_vld || backend_pkg::is_older(i_mispred_info.rob_idx, mp_info.rob_idx))) begin
            mp_info <= i_mispred_info;
        end
    end

    assign o_commit_vld     = commit;
    assign o_commit_ftq_idx = ftq_q[head[SLOT_W-1:0]];
    assign o_squash_vld     = squash;
    assign o_squash_ftq_idx = mp_info.ftq_idx;
    assign o_squash_target  = mp_info.target;

    // offsets from head, for the in-flight window check
    assign wb0_ofs = wb0.rob_idx - head;
    assign wb1_ofs = wb1.rob_idx - head;

    a_no_alloc_full: assert property (@(posedge clk) disable iff (!i_rst_n)
        occ <= `ROB_DEPTH)
        else $error("rob allocated past full");
    a_wb0_window: assert property (@(posedge clk) disable iff (!i_rst_n)
        wb0.vld |-> wb0_ofs < occ)
        else $error("lane 0 wrote back rob entry outside head..tail");
    a_wb1_window: assert property (@(posedge clk) disable iff (!i_rst_n)
        wb1.vld |-> wb1_ofs < occ)
        else $error("lane 1 wrote back rob entry outside head..tail");

endmodule

//--- rtl/aura_backend.sv
`timescale 1ns/1ps
`include "backend_consts.svh"

module aura_backend (
    input  logic                  clk,
    input  logic                  i_rst_n,

    // from fetch
    input  logic                  i_inst_vld,
    output logic                  o_inst_rdy,
    input  logic [`FTQ_IDX_W-1:0] i_inst_ftq_idx,
    input  logic [`XLEN-1:0]      i_inst_src_a,
    input  logic [`XLEN-1:0]      i_inst_src_b,
    input  logic [`XLEN-1:0]      i_inst_offset,

    // ftq block addresses per lane
    output logic [`FTQ_IDX_W-1:0] o_read_ftq_idx        [`BRU_NUM],
    input  logic [`XLEN-1:0]      i_read_ftq_start_addr [`BRU_NUM],
    input  logic [`XLEN-1:0]      i_read_ftq_next_addr  [`BRU_NUM],

    output logic                  o_commit_vld,
    output logic [`FTQ_IDX_W-1:0] o_commit_ftq_idx,
    output logic                  o_squash_vld,
    output logic [`FTQ_IDX_W-1:0] o_squash_ftq_idx,
    output logic [`XLEN-1:0]      o_squash_target
);

    disp_if   disp0 ();
    disp_if   disp1 ();
    bru_wb_if wb0 ();
    bru_wb_if wb1 ();

    logic                   sel_vld     [`BRU_NUM];
    logic [`ROB_IDX_W-1:0]  sel_rob_idx [`BRU_NUM];
    backend_pkg::branchwb_t sel_data    [`BRU_NUM];
    logic                   mispred_vld;
    backend_pkg::branchwb_t mispred_info;

    // only mispredicting writebacks compete for the oldest slot
    assign sel_vld[0]     = wb0.vld && wb0.mispred;
    assign sel_vld[1]     = wb1.vld && wb1.mispred;
    assign sel_rob_idx[0] = wb0.rob_idx;
    assign sel_rob_idx[1] = wb1.rob_idx;
    assign sel_data[0]    = '{rob_idx: wb0.rob_idx, ftq_idx: wb0.ftq_idx,
                              mispred: wb0.mispred, target: wb0.target};
    assign sel_data[1]    = '{rob_idx: wb1.rob_idx, ftq_idx: wb1.ftq_idx,
                              mispred: wb1.mispred, target: wb1.target};

    ctrl_block u_ctrl_block (
        .clk              ( clk              ),
        .i_rst_n          ( i_rst_n          ),
        .i_inst_vld       ( i_inst_vld       ),
        .o_inst_rdy       ( o_inst_rdy       ),
        .i_inst_ftq_idx   ( i_inst_ftq_idx   ),
        .i_inst_src_a     ( i_inst_src_a     ),
        .i_inst_src_b     ( i_inst_src_b     ),
        .i_inst_offset    ( i_inst_offset    ),
        .disp0            ( disp0            ),
        .disp1            ( disp1            ),
        .wb0              ( wb0              ),
        .wb1              ( wb1              ),
        .i_mispred_vld    ( mispred_vld      ),
        .i_mispred_info   ( mispred_info     ),
        .o_commit_vld     ( o_commit_vld     ),
        .o_commit_ftq_idx ( o_commit_ftq_idx ),
        .o_squash_vld     ( o_squash_vld     ),
        .o_squash_ftq_idx ( o_squash_ftq_idx ),
        .o_squash_target  ( o_squash_target  )
    );

    exe_block u_exe_block (
        .clk                   ( clk                   ),
        .i_rst_n               ( i_rst_n               ),
        .i_squash_vld          ( o_squash_vld          ),
        .disp0                 ( disp0                 ),
        .disp1                 ( disp1                 ),
        .wb0                   ( wb0                   ),
        .wb1                   ( wb1                   ),
        .o_read_ftq_idx        ( o_read_ftq_idx        ),
        .i_read_ftq_start_addr ( i_read_ftq_start_addr ),
        .i_read_ftq_next_addr  ( i_read_ftq_next_addr  )
    );

    oldest_select #(
        .dtype ( backend_pkg::branchwb_t )
    ) u_oldest_select (
        .i_vld         ( sel_vld      ),
        .i_rob_idx     ( sel_rob_idx  ),
        .i_datas       ( sel_data     ),
        .o_vld         ( mispred_vld  ),
        .o_oldest_data ( mispred_info )
    );

endmodule

//--- sim/tb_aura_backend.sv
`timescale 1ns/1ps
`include "backend_consts.svh"

module tb_aura_backend;

    localparam int MAX_OPS  = 64;
    localparam int MAX_SEGS = 16;
    localparam int FTQ_SIZE = 1 << `FTQ_IDX_W;

    logic                  clk;
    logic                  i_rst_n;
    logic                  i_inst_vld;
    logic                  o_inst_rdy;
    logic [`FTQ_IDX_W-1:0] i_inst_ftq_idx;
    logic [`XLEN-1:0]      i_inst_src_a;
    logic [`XLEN-1:0]      i_inst_src_b;
    logic [`XLEN-1:0]      i_inst_offset;
    logic [`FTQ_IDX_W-1:0] o_read_ftq_idx        [`BRU_NUM];
    logic [`XLEN-1:0]      i_read_ftq_start_addr [`BRU_NUM];
    logic [`XLEN-1:0]      i_read_ftq_next_addr  [`BRU_NUM];
    logic                  o_commit_vld;
    logic [`FTQ_IDX_W-1:0] o_commit_ftq_idx;
    logic                  o_squash_vld;
    logic [`FTQ_IDX_W-1:0] o_squash_ftq_idx;
    logic [`XLEN-1:0]      o_squash_target;

    // ftq table and micro-op segments from the golden file
    logic [`XLEN-1:0]      ftq_start [FTQ_SIZE];
    logic [`XLEN-1:0]      ftq_next  [FTQ_SIZE];
    logic [`FTQ_IDX_W-1:0] op_ftq [MAX_OPS];
    logic [`XLEN-1:0]      op_a   [MAX_OPS];
    logic [`XLEN-1:0]      op_b   [MAX_OPS];
    logic [`XLEN-1:0]      op_off [MAX_OPS];
    int                    seg_first   [MAX_SEGS];
    int                    seg_len     [MAX_SEGS];
    int                    seg_commits [MAX_SEGS];
    logic                  seg_sq      [MAX_SEGS];
    logic [`FTQ_IDX_W-1:0] seg_sq_ftq  [MAX_SEGS];
    logic [`XLEN-1:0]      seg_sq_tgt  [MAX_SEGS];
    int num_ops = 0;
    int num_segs = 0;

    int cur_seg = 0;
    int seen_commits = 0;
    int seen_squash = 0;
    int watchdog_cycles = 0;
    bit monitor_on = 0;

    aura_backend uut (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // ftq read ports answer in the same cycle
    assign i_read_ftq_start_addr[0] = ftq_start[o_read_ftq_idx[0]];
    assign i_read_ftq_next_addr[0]  = ftq_next[o_read_ftq_idx[0]];
    assign i_read_ftq_start_addr[1] = ftq_start[o_read_ftq_idx[1]];
    assign i_read_ftq_next_addr[1]  = ftq_next[o_read_ftq_idx[1]];

    task automatic abort_run(input string what);
        $display("ERROR: %s", what);
        $display("Testbench failed");
        $fatal(1, "run stopped");
    endtask

    task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %0h actual %0h", name, exp, act);
            $display("Testbench failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // taken when the operands match
    function automatic logic [`XLEN-1:0] resolve_target(input int k);
        logic [`XLEN-1:0] start;

        start = ftq_start[op_ftq[k]];
        if (op_a[k] == op_b[k]) begin
            return start + op_off[k];
        end
        return start + 32'd4;
    endfunction

    task automatic load_golden();
        int fd;
        int rc;
        int n;
        int c;
        logic [8*160-1:0] line;
        logic [8*8-1:0]   kw;
        logic [8*12-1:0]  sq_word;
        logic [`XLEN-1:0] x0, x1, x2, x3;

        fd = $fopen("sim/backend_golden.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open sim/backend_golden.txt");
        end
        while (!$feof(fd)) begin
            line = '0;
            kw = '0;
            rc = $fgets(line, fd);
            rc = $sscanf(line, "%s", kw);
            if (rc < 1 || kw == "#") begin
                continue;
            end
            if (kw == "ftq") begin
                rc = $sscanf(line, "%s %h %h %h", kw, x0, x1, x2);
                ftq_start[x0] = x1;
                ftq_next[x0]  = x2;
            end else if (kw == "seg") begin
                sq_word = '0;
                rc = $sscanf(line, "%s %d %d %s %h", kw, n, c, sq_word, x1);
                seg_first[num_segs]   = num_ops;
                seg_len[num_segs]     = n;
                seg_commits[num_segs] = c;
                seg_sq[num_segs]      = (sq_word != "none");
                rc = $sscanf(sq_word, "%h", x0);
                seg_sq_ftq[num_segs]  = x0;
                seg_sq_tgt[num_segs]  = x1;
                num_segs++;
            end else if (kw == "op") begin
                rc = $sscanf(line, "%s %h %h %h %h", kw, x0, x1, x2, x3);
                op_ftq[num_ops] = x0;
                op_a[num_ops]   = x1;
                op_b[num_ops]   = x2;
                op_off[num_ops] = x3;
                num_ops++;
            end else begin
                abort_run("golden file holds a line that is not ftq, seg or op");
            end
        end
        $fclose(fd);
    endtask

    // the first mispredict in program order decides commits and squash
    task automatic check_golden_rule();
        for (int s = 0; s < num_segs; s++) begin
            int first_mp;
            int k;

            first_mp = -1;
            for (int i = 0; i < seg_len[s]; i++) begin
                k = seg_first[s] + i;
                if (first_mp < 0 && resolve_target(k) != ftq_next[op_ftq[k]]) begin
                    first_mp = i;
                end
            end
            if (first_mp < 0) begin
                compare($sformatf("seg %0d commit count", s), seg_len[s], seg_commits[s]);
                compare($sformatf("seg %0d squash flag", s), 0, seg_sq[s]);
            end else begin
                k = seg_first[s] + first_mp;
                compare($sformatf("seg %0d commit count", s), first_mp + 1, seg_commits[s]);
                compare($sformatf("seg %0d squash flag", s), 1, seg_sq[s]);
                compare($sformatf("seg %0d squash ftq", s), op_ftq[k], seg_sq_ftq[s]);
                compare($sformatf("seg %0d squash target", s), resolve_target(k), seg_sq_tgt[s]);
            end
        end
    endtask

    task automatic check_reset_state(input string when);
        compare({when, " commit_vld"}, 0, o_commit_vld);
        compare({when, " squash_vld"}, 0, o_squash_vld);
        compare({when, " inst_rdy"}, 1, o_inst_rdy);
    endtask

    // stream one segment, stop early on a squash
    task automatic send_segment(input int s);
        int k;
        int idle;
        bit stop;

        k = 0;
        stop = 0;
        idle = $urandom % 2;
        while (!stop && k < seg_len[s]) begin
            @(negedge clk);
            if (o_squash_vld) begin
                stop = 1;
                i_inst_vld = 1'b0;
            end else if (idle > 0) begin
                idle--;
                i_inst_vld = 1'b0;
            end else begin
                i_inst_vld     = 1'b1;
                i_inst_ftq_idx = op_ftq[seg_first[s] + k];
                i_inst_src_a   = op_a[seg_first[s] + k];
                i_inst_src_b   = op_b[seg_first[s] + k];
                i_inst_offset  = op_off[seg_first[s] + k];
                if (o_inst_rdy) begin
                    k++;
                    idle = $urandom % 2;
                end
            end
        end
        @(negedge clk);
        i_inst_vld = 1'b0;
    endtask

    // commit scoreboard, program order within the segment
    always @(negedge clk) begin
        if (monitor_on && o_commit_vld) begin
            if (seen_commits >= seg_commits[cur_seg]) begin
                abort_run($sformatf("segment %0d committed more micro-ops than expected",
                                    cur_seg));
            end
            compare($sformatf("seg %0d commit %0d ftq", cur_seg, seen_commits),
                    op_ftq[seg_first[cur_seg] + seen_commits], o_commit_ftq_idx);
            seen_commits++;
        end
        if (monitor_on && o_squash_vld) begin
            if (!seg_sq[cur_seg] || seen_squash > 0) begin
                abort_run($sformatf("unexpected squash in segment %0d", cur_seg));
            end
            compare($sformatf("seg %0d squash with commit", cur_seg), 1, o_commit_vld);
            compare($sformatf("seg %0d inst_rdy during squash", cur_seg), 0, o_inst_rdy);
            compare($sformatf("seg %0d squash position", cur_seg),
                    seg_commits[cur_seg], seen_commits);
            compare($sformatf("seg %0d squash ftq", cur_seg), seg_sq_ftq[cur_seg], o_squash_ftq_idx);
            compare($sformatf("seg %0d squash target", cur_seg), seg_sq_tgt[cur_seg],
                    o_squash_target);
            seen_squash++;
        end
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        abort_run("timeout, the expected commits never arrived");
    end

    initial begin
        i_rst_n        = 1'b0;
        i_inst_vld     = 1'b0;
        i_inst_ftq_idx = '0;
        i_inst_src_a   = '0;
        i_inst_src_b   = '0;
        i_inst_offset  = '0;
        for (int i = 0; i < FTQ_SIZE; i++) begin
            ftq_start[i] = '0;
            ftq_next[i]  = '0;
        end
        void'($urandom(32'h9ae22fa4));
        load_golden();
        check_golden_rule();
        watchdog_cycles = num_ops * 60 + 20;

        repeat (4) begin
            @(negedge clk);
            check_reset_state("in reset");
        end
        i_rst_n = 1'b1;
        @(negedge clk);
        check_reset_state("after reset");
        monitor_on = 1;

        for (int s = 0; s < num_segs; s++) begin
            @(posedge clk);
            cur_seg      = s;
            seen_commits = 0;
            seen_squash  = 0;
            send_segment(s);
            while (seen_commits < seg_commits[s]) begin
                @(posedge clk);
            end
            compare($sformatf("seg %0d squash count", s), seg_sq[s], seen_squash);
        end

        // flushed micro-ops must stay gone
        repeat (8) @(negedge clk);
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- sim/backend_golden.txt
# ftq <idx> <start_addr> <next_addr>, all hex
# seg <ops> <commits> <squash_ftq|none> [<squash_target>], then its op lines
# op <ftq_idx> <src_a> <src_b> <offset>, all hex
ftq 0 00001000 00001004
ftq 1 00001040 00001080
ftq 2 00002000 00002004
ftq 3 00002100 00002180
ftq 4 00003000 00003004
ftq 5 00003100 00003120
ftq 6 00004000 00004004
ftq 7 00004200 00004240
seg 4 4 none
op 0 1 2 10
op 1 5 5 40
op 2 3 4 8
op 3 7 7 80
seg 5 3 6 00004100
op 4 1 9 20
op 5 2 2 20
op 6 6 6 100
op 7 1 1 40
op 0 1 2 0
seg 3 1 5 00003104
op 5 1 2 60
op 7 3 4 40
op 0 1 2 0
seg 10 10 none
op 0 1 2 10
op 1 5 5 40
op 2 3 4 8
op 3 7 7 80
op 4 1 9 20
op 5 2 2 20
op 0 9 8 0
op 1 0 0 40
op 2 1 1 4
op 3 2 2 80

//--- build.f
+incdir+include
rtl/backend_pkg.sv
rtl/disp_if.sv
rtl/bru_wb_if.sv
rtl/bru.sv
rtl/exe_block.sv
rtl/oldest_select.sv
rtl/ctrl_block.sv
rtl/aura_backend.sv
sim/tb_aura_backend.sv

//--- Bender.yml
package:
  name: aura_backend

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/backend_pkg.sv
      - rtl/disp_if.sv
      - rtl/bru_wb_if.sv
      - rtl/bru.sv
      - rtl/exe_block.sv
      - rtl/oldest_select.sv
      - rtl/ctrl_block.sv
      - rtl/aura_backend.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_aura_backend.sv
